//--- hdl/tlb_pkg.sv
package tlb_pkg;

   //////////////////////
   // Geometry
   //////////////////////
   localparam int VA_WIDTH      = 32;
   localparam int PA_WIDTH      = 40;
   localparam int PAGE_BITS     = 12;              // 4 kB pages
   localparam int N_SETS        = 8;
   localparam int SET_BITS      = 3;
   localparam int N_BANKS       = 4;
   localparam int BANK_BITS     = 2;
   localparam int N_STEPS       = 4;               // Entries per bank and set
   localparam int STEP_BITS     = 2;
   localparam int VA_IDX_BITS   = SET_BITS + STEP_BITS;
   localparam int PA_IDX_BITS   = VA_IDX_BITS + BANK_BITS;
   localparam int VPN_BITS      = VA_WIDTH - PAGE_BITS;
   localparam int PPN_BITS      = PA_WIDTH - PAGE_BITS;
   localparam int CFG_ADDR_BITS = 8;
   localparam int CFG_DATA_BITS = 32;
   localparam int VA_ENTRY_BITS = VPN_BITS + 3;

   // One virtual-tag entry
   typedef struct packed {
      logic                valid;
      logic                rd;                     // Read access allowed
      logic                wr;                     // Write access allowed
      logic [VPN_BITS-1:0] vpn;
   } tlb_va_entry_t;

   // Config data seen by the tag banks or by the physical table
   typedef union packed {
      struct packed {
         logic [CFG_DATA_BITS-VA_ENTRY_BITS-1:0] pad;
         tlb_va_entry_t                          entry;
      } va;
      struct packed {
         logic [CFG_DATA_BITS-PPN_BITS-1:0] pad;
         logic [PPN_BITS-1:0]               ppn;
      } pa;
   } tlb_cfg_word_u;

endpackage

//--- hdl/tlb_search_seq.sv
`timescale 1ns/1ps

module tlb_search_seq (
   input  logic                              clk_i,
   input  logic                              rst_ni,
   input  logic                              start_i,
   input  logic [tlb_pkg::VA_WIDTH-1:0]      va_i,
   input  logic                              rw_i,
   input  logic                              cfg_va_we_i,
   input  logic                              v_valid_i,
   input  logic                              v_hit_i,
   input  logic                              v_prot_i,
   input  logic                              v_multi_i,
   input  logic                              v_last_i,
   input  logic                              result_sent_i,
   output logic                              busy_o,
   output logic                              rd_en_o,
   output logic [tlb_pkg::VA_IDX_BITS-1:0]   rd_idx_o,
   output logic [tlb_pkg::VPN_BITS-1:0]      req_vpn_o,
   output logic                              req_rw_o,
   output logic [tlb_pkg::PAGE_BITS-1:0]     req_offset_o,
   output logic                              search_done_o
);
   import tlb_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_SEARCH, S_DONE} state_t;

   state_t               state_q, state_d;
   logic [STEP_BITS-1:0] step_q;
   logic                 issued_all_q;     // Last step already sent to the banks
   logic [VA_WIDTH-1:0]  va_q;
   logic                 rw_q;
   logic                 accept;
   logic                 stop;

   assign accept = start_i & (state_q == S_IDLE);
   assign stop   = v_valid_i & (v_hit_i | v_prot_i | v_multi_i | v_last_i);

   assign busy_o        = (state_q != S_IDLE);
   assign search_done_o = (state_q == S_SEARCH) & stop;
   // Tag writes own the bank port for that cycle
   assign rd_en_o       = (state_q == S_SEARCH) & ~issued_all_q & ~cfg_va_we_i;

   assign rd_idx_o     = {va_q[PAGE_BITS +: SET_BITS], step_q};
   assign req_vpn_o    = va_q[VA_WIDTH-1:PAGE_BITS];
   assign req_offset_o = va_q[PAGE_BITS-1:0];
   assign req_rw_o     = rw_q;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         S_IDLE:   if (start_i) state_d = S_SEARCH;
         S_SEARCH: if (stop) state_d = S_DONE;
         S_DONE:   if (result_sent_i) state_d = S_IDLE;
         default:  state_d = S_IDLE;
      endcase
   end

   //////////////////////
   // Step counter
   //////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q      <= S_IDLE;
         step_q       <= '0;
         issued_all_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            step_q       <= '0;
            issued_all_q <= 1'b0;
         end else if (rd_en_o) begin
            if (step_q == STEP_BITS'(N_STEPS-1)) begin
               issued_all_q <= 1'b1;
            end else begin
               step_q <= step_q + 1'b1;
            end
         end
      end
   end

   // Request is held until the result has gone out
   always_ff @(posedge clk_i) begin
      if (accept) begin
         va_q <= va_i;
         rw_q <= rw_i;
      end
   end

endmodule

//--- hdl/tlb_va_banks.sv
`timescale 1ns/1ps

module tlb_va_banks (
   input  logic                                                clk_i,
   input  logic                                                rst_ni,
   input  logic                                                cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_BITS-1:0]                   cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_BITS-1:0]                   cfg_data_i,
   input  logic                                                rd_en_i,
   input  logic [tlb_pkg::VA_IDX_BITS-1:0]                     rd_idx_i,
   output logic                                                cfg_va_we_o,
   output logic                                                rd_valid_o,
   output logic [tlb_pkg::VA_IDX_BITS-1:0]                     rd_idx_o,
   output tlb_pkg::tlb_va_entry_t [tlb_pkg::N_BANKS-1:0]       bank_q_o
);
   import tlb_pkg::*;

   localparam int DEPTH = 2**VA_IDX_BITS;

   tlb_va_entry_t          mem_q [N_BANKS][DEPTH];
   tlb_cfg_word_u          cfg_word;
   logic [BANK_BITS-1:0]   wr_bank;
   logic [VA_IDX_BITS-1:0] wr_idx;

   assign cfg_word    = cfg_data_i;
   assign cfg_va_we_o = cfg_we_i & ~cfg_addr_i[CFG_ADDR_BITS-1];   // Region 0 is the tag banks
   assign wr_bank     = cfg_addr_i[BANK_BITS-1:0];
   assign wr_idx      = cfg_addr_i[BANK_BITS +: VA_IDX_BITS];

   always_ff @(posedge clk_i) begin
      if (cfg_va_we_o) begin
         mem_q[wr_bank][wr_idx] <= cfg_word.va.entry;
      end
   end

   // All banks read at the same word
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_idx_o <= rd_idx_i;
         for (int b = 0; b < N_BANKS; b++) begin
            bank_q_o[b] <= mem_q[b][rd_idx_i];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

//--- hdl/tlb_match.sv
`timescale 1ns/1ps

module tlb_match (
   input  logic                                          clk_i,
   input  logic                                          rst_ni,
   input  logic                                          rd_valid_i,
   input  logic [tlb_pkg::VA_IDX_BITS-1:0]               rd_idx_i,
   input  tlb_pkg::tlb_va_entry_t [tlb_pkg::N_BANKS-1:0] bank_q_i,
   input  logic [tlb_pkg::VPN_BITS-1:0]                  req_vpn_i,
   input  logic                                          req_rw_i,
   output logic                                          v_valid_o,
   output logic                                          v_hit_o,
   output logic                                          v_prot_o,
   output logic                                          v_multi_o,
   output logic                                          v_last_o,
   output logic [tlb_pkg::PA_IDX_BITS-1:0]               v_pa_idx_o
);
   import tlb_pkg::*;

   logic [N_BANKS-1:0]   match;
   logic [BANK_BITS-1:0] hit_bank;
   logic                 any_hit;
   logic                 multi;
   logic                 forbidden;

   always_comb begin
      hit_bank = '0;
      for (int b = N_BANKS-1; b >= 0; b--) begin
         match[b] = bank_q_i[b].valid & (bank_q_i[b].vpn == req_vpn_i);
         if (match[b]) begin
            hit_bank = BANK_BITS'(b);      // Lowest bank wins
         end
      end
   end

   assign any_hit   = |match;
   assign multi     = |(match & (match - 1'b1));     // More than one bit set
   assign forbidden = req_rw_i ? ~bank_q_i[hit_bank].wr : ~bank_q_i[hit_bank].rd;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         v_valid_o <= 1'b0;
      end else begin
         v_valid_o <= rd_valid_i;
      end
   end

   // Verdict payload qualified by v_valid_o
   always_ff @(posedge clk_i) begin
      if (rd_valid_i) begin
         v_hit_o    <= any_hit;
         v_multi_o  <= multi;
         v_prot_o   <= any_hit & ~multi & forbidden;
         v_last_o   <= (rd_idx_i[STEP_BITS-1:0] == STEP_BITS'(N_STEPS-1));
         v_pa_idx_o <= {rd_idx_i, hit_bank};
      end
   end

endmodule

//--- hdl/tlb_result.sv
`timescale 1ns/1ps

module tlb_result (
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  logic                                cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_BITS-1:0]   cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_BITS-1:0]   cfg_data_i,
   input  logic                                search_done_i,
   input  logic                                v_hit_i,
   input  logic                                v_prot_i,
   input  logic                                v_multi_i,
   input  logic [tlb_pkg::PA_IDX_BITS-1:0]     v_pa_idx_i,
   input  logic [tlb_pkg::PAGE_BITS-1:0]       req_offset_i,
   input  logic                                out_ready_i,
   output logic                                out_valid_o,
   output logic                                hit_o,
   output logic                                miss_o,
   output logic                                prot_o,
   output logic                                multi_o,
   output logic [tlb_pkg::PA_WIDTH-1:0]        pa_o,
   output logic                                result_sent_o
);
   import tlb_pkg::*;

   typedef enum logic [1:0] {R_IDLE, R_WAIT_WR, R_READ, R_SEND} state_t;

   state_t                 state_q, state_d;
   logic [PPN_BITS-1:0]    pa_mem [2**PA_IDX_BITS];
   tlb_cfg_word_u          cfg_word;
   logic                   pa_we;
   logic                   clean_hit;
   logic                   rd_now;
   logic [PA_IDX_BITS-1:0] idx_q;
   logic [PAGE_BITS-1:0]   offset_q;
   logic [PPN_BITS-1:0]    ppn_q;

   assign cfg_word  = cfg_data_i;
   assign pa_we     = cfg_we_i & cfg_addr_i[CFG_ADDR_BITS-1];
   assign clean_hit = v_hit_i & ~v_prot_i & ~v_multi_i;
   // Table read only in a cycle free of config writes
   assign rd_now    = ((state_q == R_READ) | (state_q == R_WAIT_WR)) & ~pa_we;

   assign out_valid_o   = (state_q == R_SEND);
   assign result_sent_o = out_valid_o & out_ready_i;
   assign pa_o          = (hit_o & ~prot_o & ~multi_o) ? {ppn_q, offset_q} : '0;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         R_IDLE:    if (search_done_i) state_d = clean_hit ? R_READ : R_SEND;
         R_READ:    state_d = pa_we ? R_WAIT_WR : R_SEND;
         R_WAIT_WR: if (!pa_we) state_d = R_SEND;
         R_SEND:    if (out_ready_i) state_d = R_IDLE;
         default:   state_d = R_IDLE;
      endcase
   end

   //////////////////////
   // Flags
   //////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= R_IDLE;
         hit_o   <= 1'b0;
         miss_o  <= 1'b0;
         prot_o  <= 1'b0;
         multi_o <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == R_IDLE && search_done_i) begin
            hit_o   <= v_hit_i;
            miss_o  <= ~v_hit_i;
            prot_o  <= v_prot_i;
            multi_o <= v_multi_i;
         end else if (result_sent_o) begin
            hit_o   <= 1'b0;
            miss_o  <= 1'b0;
            prot_o  <= 1'b0;
            multi_o <= 1'b0;
         end
      end
   end

   //////////////////////
   // Physical table
   //////////////////////
   always_ff @(posedge clk_i) begin
      if (pa_we) begin
         pa_mem[cfg_addr_i[PA_IDX_BITS-1:0]] <= cfg_word.pa.ppn;
      end
      if (state_q == R_IDLE && search_done_i) begin
         idx_q    <= v_pa_idx_i;
         offset_q <= req_offset_i;
      end
      if (rd_now) begin
         ppn_q <= pa_mem[idx_q];
      end
   end

endmodule

//--- hdl/tlb_top.sv
`timescale 1ns/1ps

module tlb_top (
   input  logic                              clk_i,
   input  logic                              rst_ni,
   input  logic                              cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_BITS-1:0] cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_BITS-1:0] cfg_data_i,
   input  logic                              start_i,
   input  logic [tlb_pkg::VA_WIDTH-1:0]      va_i,
   input  logic                              rw_i,        // 1 is a write access
   output logic                              busy_o,
   input  logic                              out_ready_i,
   output logic                              out_valid_o,
   output logic                              hit_o,
   output logic                              miss_o,
   output logic                              prot_o,
   output logic                              multi_o,
   output logic [tlb_pkg::PA_WIDTH-1:0]      pa_o
);
   import tlb_pkg::*;

   logic                          cfg_va_we, rd_en, rd_valid;
   logic [VA_IDX_BITS-1:0]        rd_idx, rd_idx_q;
   tlb_va_entry_t [N_BANKS-1:0]   bank_q;
   logic [VPN_BITS-1:0]           req_vpn;
   logic                          req_rw;
   logic [PAGE_BITS-1:0]          req_offset;
   logic                          v_valid, v_hit, v_prot, v_multi, v_last;
   logic [PA_IDX_BITS-1:0]        v_pa_idx;
   logic                          search_done, result_sent;

   tlb_search_seq u_search_seq (
      .clk_i, .rst_ni, .start_i, .va_i, .rw_i,
      .cfg_va_we_i   (cfg_va_we),
      .v_valid_i     (v_valid),
      .v_hit_i       (v_hit),
      .v_prot_i      (v_prot),
      .v_multi_i     (v_multi),
      .v_last_i      (v_last),
      .result_sent_i (result_sent),
      .busy_o,
      .rd_en_o       (rd_en),
      .rd_idx_o      (rd_idx),
      .req_vpn_o     (req_vpn),
      .req_rw_o      (req_rw),
      .req_offset_o  (req_offset),
      .search_done_o (search_done)
   );

   tlb_va_banks u_va_banks (
      .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_data_i,
      .rd_en_i     (rd_en),
      .rd_idx_i    (rd_idx),
      .cfg_va_we_o (cfg_va_we),
      .rd_valid_o  (rd_valid),
      .rd_idx_o    (rd_idx_q),
      .bank_q_o    (bank_q)
   );

   tlb_match u_match (
      .clk_i, .rst_ni,
      .rd_valid_i (rd_valid),
      .rd_idx_i   (rd_idx_q),
      .bank_q_i   (bank_q),
      .req_vpn_i  (req_vpn),
      .req_rw_i   (req_rw),
      .v_valid_o  (v_valid),
      .v_hit_o    (v_hit),
      .v_prot_o   (v_prot),
      .v_multi_o  (v_multi),
      .v_last_o   (v_last),
      .v_pa_idx_o (v_pa_idx)
   );

   tlb_result u_result (
      .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_data_i,
      .search_done_i (search_done),
      .v_hit_i       (v_hit),
      .v_prot_i      (v_prot),
      .v_multi_i     (v_multi),
      .v_pa_idx_i    (v_pa_idx),
      .req_offset_i  (req_offset),
      .out_ready_i,
      .out_valid_o, .hit_o, .miss_o, .prot_o, .multi_o, .pa_o,
      .result_sent_o (result_sent)
   );

endmodule

//--- sim/tlb_properties.sv
`timescale 1ns/1ps

module tlb_properties (
   input logic                            clk_i,
   input logic                            rst_ni,
   input logic                            busy_i,
   input logic                            out_valid_i,
   input logic                            out_ready_i,
   input logic                            hit_i,
   input logic                            miss_i,
   input logic                            prot_i,
   input logic                            multi_i,
   input logic [tlb_pkg::PA_WIDTH-1:0]    pa_i
);
   int unsigned fail_count;      // Read by the testbench at the end

   initial fail_count = 0;

   //////////////////////
   // Output handshake
   //////////////////////
   result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(hit_i) && $stable(miss_i)
         && $stable(prot_i) && $stable(multi_i) && $stable(pa_i)))
      else begin
         $error("Result changed while out_ready_i was low");
         fail_count++;
      end

   // A miss carries no fault flags and no address
   hit_or_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_i |-> ((hit_i ^ miss_i) && !(prot_i && multi_i)
         && (hit_i || (!prot_i && !multi_i && pa_i == '0))))
      else begin
         $error("Result flags do not fit together");
         fail_count++;
      end

   busy_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_i |-> busy_i)
      else begin
         $error("Result valid while not busy");
         fail_count++;
      end

   idle_after_reset: assert property (@(posedge clk_i)
      !rst_ni |=> (!busy_i && !out_valid_i))
      else begin
         $error("Busy or valid set right after reset");
         fail_count++;
      end

endmodule

bind tlb_top tlb_properties u_properties (
   .clk_i       (clk_i),
   .rst_ni      (rst_ni),
   .busy_i      (busy_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .hit_i       (hit_o),
   .miss_i      (miss_o),
   .prot_i      (prot_o),
   .multi_i     (multi_o),
   .pa_i        (pa_o)
);

//--- sim/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;
   import tlb_pkg::*;

   localparam int TIMEOUT = 100;             // Cycles per wait

   logic                     clk_i, rst_ni, cfg_we_i, start_i, rw_i, busy_o, out_ready_i;
   logic [CFG_ADDR_BITS-1:0] cfg_addr_i;
   logic [CFG_DATA_BITS-1:0] cfg_data_i;
   logic [VA_WIDTH-1:0]      va_i;
   logic                     out_valid_o, hit_o, miss_o, prot_o, multi_o;
   logic [PA_WIDTH-1:0]      pa_o;

   tlb_va_entry_t       tag_shadow [N_BANKS][2**VA_IDX_BITS];
   logic [PPN_BITS-1:0] ppn_shadow [2**PA_IDX_BITS];
   integer              seed = 32'h9cec;
   int                  errors = 0;
   int                  checks = 0;
   logic                timed_out = 1'b0;
   logic [31:0]         rnd, rnd2;
   logic [SET_BITS-1:0] set_sel;
   tlb_va_entry_t       stim_entry;

   tlb_top u_tlb_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   //////////////////////
   // Helpers
   //////////////////////
   task automatic expect_value(input string name, input logic [PA_WIDTH-1:0] exp,
                               input logic [PA_WIDTH-1:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   task automatic report_timeout(input string what);
      errors++;
      timed_out = 1'b1;
      $display("Timeout at %0t while waiting for %s", $time, what);
   endtask

   task automatic write_cfg(input logic [CFG_ADDR_BITS-1:0] addr,
                            input logic [CFG_DATA_BITS-1:0] data);
      cfg_we_i   = 1'b1;
      cfg_addr_i = addr;
      cfg_data_i = data;
      @(posedge clk_i);
      #2;
      cfg_we_i = 1'b0;
   endtask

   task automatic write_tag(input logic [BANK_BITS-1:0] bank,
                            input logic [VA_IDX_BITS-1:0] idx, input tlb_va_entry_t e);
      tag_shadow[bank][idx] = e;
      write_cfg({1'b0, idx, bank}, CFG_DATA_BITS'(e));
   endtask

   task automatic write_ppn(input logic [PA_IDX_BITS-1:0] idx, input logic [PPN_BITS-1:0] ppn);
      ppn_shadow[idx] = ppn;
      write_cfg({1'b1, idx}, CFG_DATA_BITS'(ppn));
   endtask

   // Random entry whose tag indexes its own set
   function automatic tlb_va_entry_t make_entry(input logic [SET_BITS-1:0] set_idx);
      tlb_va_entry_t e;
      logic [31:0]   r;
      r = $random(seed);
      e.valid = (r[31:30] != 2'b00);
      e.rd    = r[29];
      e.wr    = r[28];
      e.vpn   = {r[VPN_BITS-SET_BITS-1:0], set_idx};
      return e;
   endfunction

   task automatic load_tables();
      logic [31:0] r;
      for (int i = 0; i < 2**VA_IDX_BITS; i++) begin
         for (int b = 0; b < N_BANKS; b++) begin
            write_tag(BANK_BITS'(b), VA_IDX_BITS'(i), make_entry(SET_BITS'(i >> STEP_BITS)));
         end
      end
      for (int i = 0; i < 2**PA_IDX_BITS; i++) begin
         r = $random(seed);
         write_ppn(PA_IDX_BITS'(i), r[PPN_BITS-1:0]);
      end
   endtask

   // Reference model where the first step with a match decides and the lowest bank wins
   function automatic void predict(input logic [VA_WIDTH-1:0] va, input logic rw,
                                   output logic hit, output logic prot, output logic multi,
                                   output logic [PA_IDX_BITS-1:0] idx);
      logic [SET_BITS-1:0] set_idx;
      tlb_va_entry_t       e;
      int                  n;
      int                  first;
      set_idx = va[PAGE_BITS +: SET_BITS];
      hit = 1'b0;
      prot = 1'b0;
      multi = 1'b0;
      idx = '0;
      for (int k = 0; k < N_STEPS; k++) begin
         n = 0;
         first = 0;
         for (int b = 0; b < N_BANKS; b++) begin
            e = tag_shadow[b][{set_idx, STEP_BITS'(k)}];
            if (e.valid && e.vpn == va[VA_WIDTH-1:PAGE_BITS]) begin
               if (n == 0) first = b;
               n++;
            end
         end
         if (!hit && n > 0) begin
            hit = 1'b1;
            multi = (n > 1);
            idx = {set_idx, STEP_BITS'(k), BANK_BITS'(first)};
            e = tag_shadow[first][{set_idx, STEP_BITS'(k)}];
            prot = !multi && (rw ? !e.wr : !e.rd);
         end
      end
   endfunction

   // One request with tag writes to other sets and then PPN writes during the search
   task automatic translate(input logic [VA_WIDTH-1:0] va, input logic rw, input int hold,
                            input int n_tag, input int n_pa);
      logic                   hit, prot, multi;
      logic [PA_IDX_BITS-1:0] idx;
      logic [PA_WIDTH-1:0]    pa;
      logic [31:0]            r;
      logic [SET_BITS-1:0]    other;
      int                     cycles;
      if (timed_out) return;
      cycles = 0;
      while (busy_o && cycles < TIMEOUT) begin
         @(posedge clk_i);
         #2;
         cycles++;
      end
      if (busy_o) begin
         report_timeout("busy_o to fall");
         return;
      end
      start_i = 1'b1;
      va_i    = va;
      rw_i    = rw;
      @(posedge clk_i);
      #2;
      start_i = 1'b0;
      predict(va, rw, hit, prot, multi, idx);
      for (int i = 0; i < n_tag; i++) begin
         r = $random(seed);
         other = va[PAGE_BITS +: SET_BITS] ^ {r[2:1], 1'b1};     // Never the searched set
         write_tag(r[4:3], {other, r[6:5]}, make_entry(other));
      end
      for (int i = 0; i < n_pa; i++) begin
         r = $random(seed);
         write_ppn(idx, r[PPN_BITS-1:0]);
      end
      pa = (hit && !prot && !multi) ? {ppn_shadow[idx], va[PAGE_BITS-1:0]} : '0;
      cycles = 0;
      while (!out_valid_o && cycles < TIMEOUT) begin
         @(posedge clk_i);
         #2;
         cycles++;
      end
      if (!out_valid_o) begin
         report_timeout("out_valid_o");
         return;
      end
      repeat (hold) begin
         @(posedge clk_i);
         #2;
      end
      expect_value("hit_o", hit, hit_o);
      expect_value("miss_o", !hit, miss_o);
      expect_value("prot_o", prot, prot_o);
      expect_value("multi_o", multi, multi_o);
      expect_value("pa_o", pa, pa_o);
      out_ready_i = 1'b1;
      @(posedge clk_i);
      #2;
      out_ready_i = 1'b0;
   endtask

   //////////////////////
   // Stimulus
   //////////////////////
   initial begin
      rst_ni      = 1'b0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = '0;
      cfg_data_i  = '0;
      start_i     = 1'b0;
      va_i        = '0;
      rw_i        = 1'b0;
      out_ready_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
      load_tables();
      // Clean hits on every step
      for (int k = 0; k < N_STEPS; k++) begin
         rnd = $random(seed);
         set_sel = rnd[2:0];
         stim_entry = make_entry(set_sel);
         stim_entry.valid = 1'b1;
         stim_entry.rd = 1'b1;
         stim_entry.wr = 1'b1;
         write_tag(rnd[4:3], {set_sel, STEP_BITS'(k)}, stim_entry);
         // Step 0 overlaps its table read with PPN writes
         translate({stim_entry.vpn, rnd[16:5]}, rnd[17], 0, 0, (k == 0) ? 6 : 0);
      end
      rnd = $random(seed);
      translate(rnd, 1'b0, 0, 0, 0);                      // Unknown tag gives a miss
      // Write to a read-only page, then read a write-only page
      stim_entry = make_entry(3'd5);
      stim_entry.valid = 1'b1;
      stim_entry.rd = 1'b1;
      stim_entry.wr = 1'b0;
      write_tag(2'd1, {3'd5, 2'd1}, stim_entry);
      translate({stim_entry.vpn, 12'h3a4}, 1'b1, 0, 0, 0);
      stim_entry.rd = 1'b0;
      stim_entry.wr = 1'b1;
      write_tag(2'd1, {3'd5, 2'd1}, stim_entry);
      translate({stim_entry.vpn, 12'h07c}, 1'b0, 0, 0, 0);
      // Same tag in two banks of one step
      stim_entry = make_entry(3'd2);
      stim_entry.valid = 1'b1;
      write_tag(2'd0, {3'd2, 2'd2}, stim_entry);
      write_tag(2'd2, {3'd2, 2'd2}, stim_entry);
      translate({stim_entry.vpn, 12'hfff}, 1'b0, 0, 0, 0);
      // Stored and random tags with back-pressure and config traffic
      for (int i = 0; i < 40; i++) begin
         rnd = $random(seed);
         rnd2 = $random(seed);
         stim_entry = tag_shadow[rnd[4:3]][{rnd[2:0], rnd[6:5]}];
         if (rnd[9:8] == 2'b00) begin
            stim_entry.vpn = rnd[31:12];
         end
         translate({stim_entry.vpn, rnd2[11:0]}, rnd2[12], int'(rnd2[15:13]),
                   int'(rnd2[17:16]), int'(rnd2[20:18]) % 5);
      end
      $display("Checks run: %0d, failed checks: %0d, failed assertions: %0d",
               checks, errors, u_tlb_top.u_properties.fail_count);
      if (errors == 0 && u_tlb_top.u_properties.fail_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
hdl/tlb_pkg.sv
hdl/tlb_search_seq.sv
hdl/tlb_va_banks.sv
hdl/tlb_match.sv
hdl/tlb_result.sv
hdl/tlb_top.sv
sim/tlb_properties.sv
sim/tlb_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module tlb_tb -o tlb_sim

# Bound assertion failures are counted by the testbench instead of stopping the run
sim_out=$(./obj_dir/tlb_sim +verilator+error+limit+1000 2>&1) || true
echo "$sim_out"

echo "$sim_out" | grep -q "^TESTBENCH PASSED$"
